//--- design/cpu_pkg.sv
package cpu_pkg;

  localparam int NUM_LANES = 2;
  localparam int NUM_REGS = 32;
  // two operand reads per lane
  localparam int NUM_RD_PORTS = 2 * NUM_LANES;

  ////////////////////////////////////////
  // instruction field positions
  ////////////////////////////////////////

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;

  localparam int RS_MSB = 25;
  localparam int RS_LSB = 21;

  localparam int RT_MSB = 20;
  localparam int RT_LSB = 16;

  localparam int RD_MSB = 15;
  localparam int RD_LSB = 11;

  localparam int SHAMT_MSB = 10;
  localparam int SHAMT_LSB = 6;

  // overlaps rd and shamt
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [31:0] inst_t;
  typedef logic [31:0] data_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [IMM_MSB-IMM_LSB:0] imm_t;
  typedef logic [SHAMT_MSB-SHAMT_LSB:0] shamt_t;

  // anything not listed here is a no-op
  typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,
    OP_SLL  = 6'd7,
    OP_ADDI = 6'd8,
    OP_ORI  = 6'd9
  } opcode_t;

  // second = younger half of a split pair still to go
  typedef enum logic {
    STEER_PAIR,
    STEER_SECOND
  } steer_state_t;

endpackage

//--- design/issue_steer.sv
module issue_steer import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pair_valid,
  input  inst_t     inst0,
  input  inst_t     inst1,
  output logic      hold,
  output logic      issue_valid [NUM_LANES],
  output inst_t     issue_inst [NUM_LANES],
  output reg_addr_t issue_dst [NUM_LANES],
  output logic      issue_wen [NUM_LANES]
);

  steer_state_t state;
  steer_state_t state_next;

  inst_t     pair_inst [NUM_LANES];
  reg_addr_t dec_dst [NUM_LANES];
  logic      dec_wen [NUM_LANES];
  logic      src_sel;
  logic      lane1_go;

  assign pair_inst[0] = inst0;
  assign pair_inst[1] = inst1;

  ////////////////////////////////////////
  // destination decode
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      case (opcode_t'(pair_inst[i][OPCODE_MSB:OPCODE_LSB]))
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL: begin
          dec_dst[i] = pair_inst[i][RD_MSB:RD_LSB];
          dec_wen[i] = 1'b1;
        end
        OP_ADDI, OP_ORI: begin
          dec_dst[i] = pair_inst[i][RT_MSB:RT_LSB];
          dec_wen[i] = 1'b1;
        end
        default: begin
          dec_dst[i] = pair_inst[i][RD_MSB:RD_LSB];
          dec_wen[i] = 1'b0;
        end
      endcase
      // r0 writes are dropped here already
      dec_wen[i] = dec_wen[i] && (dec_dst[i] != '0);
    end
  end

  // both source fields compared even for immediates
  assign hold = pair_valid && (state == STEER_PAIR) && dec_wen[0] &&
                ((dec_dst[0] == inst1[RS_MSB:RS_LSB]) ||
                 (dec_dst[0] == inst1[RT_MSB:RT_LSB]));

  assign src_sel  = (state == STEER_SECOND);
  assign lane1_go = pair_valid && (state == STEER_PAIR) && !hold;

  always_comb begin
    state_next = state;
    case (state)
      STEER_PAIR:   if (hold) state_next = STEER_SECOND;
      STEER_SECOND: if (pair_valid) state_next = STEER_PAIR;
      default:      state_next = STEER_PAIR;
    endcase
  end

  ////////////////////////////////////////
  // issue slots
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= STEER_PAIR;
      for (int i = 0; i < NUM_LANES; i++) begin
        issue_valid[i] <= 1'b0;
        issue_wen[i] <= 1'b0;
      end
    end else begin
      state <= state_next;
      issue_valid[0] <= pair_valid;
      issue_wen[0] <= pair_valid && dec_wen[src_sel];
      issue_valid[1] <= lane1_go;
      issue_wen[1] <= lane1_go && dec_wen[1];
    end
  end

  always_ff @(posedge clk) begin
    issue_inst[0] <= pair_inst[src_sel];
    issue_dst[0] <= dec_dst[src_sel];
    issue_inst[1] <= inst1;
    issue_dst[1] <= dec_dst[1];
  end

  // a dependent pair must have been split by hold
  a_no_paired_dep: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_valid[1] && issue_wen[0]) |->
      ((issue_dst[0] != issue_inst[1][RS_MSB:RS_LSB]) &&
       (issue_dst[0] != issue_inst[1][RT_MSB:RT_LSB])));

endmodule

//--- design/alu_lane.sv
module alu_lane import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue_valid,
  input  inst_t     issue_inst,
  input  reg_addr_t issue_dst,
  input  logic      issue_wen,
  output reg_addr_t rd_addr_a,
  output reg_addr_t rd_addr_b,
  input  data_t     rd_data_a,
  input  data_t     rd_data_b,
  input  logic      fwd_valid [NUM_LANES],
  input  reg_addr_t fwd_dst [NUM_LANES],
  input  data_t     fwd_data [NUM_LANES],
  output logic      retire_valid,
  output reg_addr_t retire_dst,
  output data_t     retire_data
);

  // read stage registers
  opcode_t   r_op;
  shamt_t    r_shamt;
  imm_t      r_imm;
  reg_addr_t r_src_a;
  reg_addr_t r_src_b;
  reg_addr_t r_dst;
  logic      r_wen;
  data_t     r_opa;
  data_t     r_opb;

  // execute
  data_t ex_a;
  data_t ex_b;
  data_t alu_out;

  assign rd_addr_a = issue_inst[RS_MSB:RS_LSB];
  assign rd_addr_b = issue_inst[RT_MSB:RT_LSB];

  ////////////////////////////////////////
  // read stage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_wen <= 1'b0;
    end else begin
      r_wen <= issue_wen;
    end
  end

  always_ff @(posedge clk) begin
    // empty slot runs as a nop
    r_op <= issue_valid ? opcode_t'(issue_inst[OPCODE_MSB:OPCODE_LSB]) : OP_NOP;
    r_shamt <= issue_inst[SHAMT_MSB:SHAMT_LSB];
    r_imm <= issue_inst[IMM_MSB:IMM_LSB];
    r_src_a <= rd_addr_a;
    r_src_b <= rd_addr_b;
    r_dst <= issue_dst;
    r_opa <= rd_data_a;
    r_opb <= rd_data_b;
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  // retire regs of all lanes hold the instructions one step older
  always_comb begin
    ex_a = r_opa;
    ex_b = r_opb;
    // ascending order so lane 1 overrides lane 0
    for (int i = 0; i < NUM_LANES; i++) begin
      if (fwd_valid[i] && (fwd_dst[i] != '0)) begin
        if (fwd_dst[i] == r_src_a) begin
          ex_a = fwd_data[i];
        end
        if (fwd_dst[i] == r_src_b) begin
          ex_b = fwd_data[i];
        end
      end
    end
  end

  always_comb begin
    case (r_op)
      OP_ADD:  alu_out = ex_a + ex_b;
      OP_SUB:  alu_out = ex_a - ex_b;
      OP_AND:  alu_out = ex_a & ex_b;
      OP_OR:   alu_out = ex_a | ex_b;
      OP_XOR:  alu_out = ex_a ^ ex_b;
      OP_SLT:  alu_out = ($signed(ex_a) < $signed(ex_b)) ? data_t'(1) : '0;
      OP_SLL:  alu_out = ex_b << r_shamt;
      // immediates are zero-extended
      OP_ADDI: alu_out = ex_a + data_t'(r_imm);
      OP_ORI:  alu_out = ex_a | data_t'(r_imm);
      default: alu_out = '0;
    endcase
  end

  ////////////////////////////////////////
  // retire register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= r_wen;
    end
  end

  always_ff @(posedge clk) begin
    retire_dst <= r_dst;
    retire_data <= alu_out;
  end

  // r0 writes are filtered back at issue
  a_no_r0_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> (retire_dst != '0));

endmodule

//--- design/register_file.sv
module register_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_en [NUM_LANES],
  input  reg_addr_t wr_addr [NUM_LANES],
  input  data_t     wr_data [NUM_LANES],
  input  reg_addr_t rd_addr [NUM_RD_PORTS],
  output data_t     rd_data [NUM_RD_PORTS]
);

  data_t regs [NUM_REGS];

  ////////////////////////////////////////
  // write ports
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // lane 1 last so the younger write lands
      for (int i = 0; i < NUM_LANES; i++) begin
        if (wr_en[i] && (wr_addr[i] != '0)) begin
          regs[wr_addr[i]] <= wr_data[i];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  // bypass the write landing at the coming edge
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_data[p] = regs[rd_addr[p]];
      for (int i = 0; i < NUM_LANES; i++) begin
        if (wr_en[i] && (wr_addr[i] == rd_addr[p])) begin
          rd_data[p] = wr_data[i];
        end
      end
      if (rd_addr[p] == '0) begin
        rd_data[p] = '0;
      end
    end
  end

endmodule

//--- design/dual_issue_core.sv
module dual_issue_core import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pair_valid,
  input  inst_t     inst0,
  input  inst_t     inst1,
  output logic      hold,
  output logic      retire_valid [NUM_LANES],
  output reg_addr_t retire_dst [NUM_LANES],
  output data_t     retire_data [NUM_LANES]
);

  logic      issue_valid [NUM_LANES];
  inst_t     issue_inst [NUM_LANES];
  reg_addr_t issue_dst [NUM_LANES];
  logic      issue_wen [NUM_LANES];

  // ports 2g and 2g+1 belong to lane g
  reg_addr_t rd_addr [NUM_RD_PORTS];
  data_t     rd_data [NUM_RD_PORTS];

  issue_steer u_steer (
    .clk         (clk),
    .rst_n       (rst_n),
    .pair_valid  (pair_valid),
    .inst0       (inst0),
    .inst1       (inst1),
    .hold        (hold),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .issue_dst   (issue_dst),
    .issue_wen   (issue_wen)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    alu_lane u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid[g]),
      .issue_inst   (issue_inst[g]),
      .issue_dst    (issue_dst[g]),
      .issue_wen    (issue_wen[g]),
      .rd_addr_a    (rd_addr[2*g]),
      .rd_addr_b    (rd_addr[2*g+1]),
      .rd_data_a    (rd_data[2*g]),
      .rd_data_b    (rd_data[2*g+1]),
      .fwd_valid    (retire_valid),
      .fwd_dst      (retire_dst),
      .fwd_data     (retire_data),
      .retire_valid (retire_valid[g]),
      .retire_dst   (retire_dst[g]),
      .retire_data  (retire_data[g])
    );
  end

  register_file u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (retire_valid),
    .wr_addr (retire_dst),
    .wr_data (retire_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- bench/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural state under strict in-order execution
data_t model_regs [NUM_REGS];

// one instruction against model_regs
// returns 1 when a nonzero register gets written
function automatic logic apply_inst(
  input  inst_t     inst,
  output reg_addr_t dst,
  output data_t     value
);
  logic [5:0] op;
  data_t      src_a;
  data_t      src_b;
  imm_t       imm;
  shamt_t     sh;
  logic       writes;

  op = inst[OPCODE_MSB:OPCODE_LSB];
  src_a = model_regs[inst[RS_MSB:RS_LSB]];
  src_b = model_regs[inst[RT_MSB:RT_LSB]];
  imm = inst[IMM_MSB:IMM_LSB];
  sh = inst[SHAMT_MSB:SHAMT_LSB];
  writes = 1'b1;
  dst = inst[RD_MSB:RD_LSB];
  value = '0;

  case (op)
    OP_ADD: value = src_a + src_b;
    OP_SUB: value = src_a - src_b;
    OP_AND: value = src_a & src_b;
    OP_OR:  value = src_a | src_b;
    OP_XOR: value = src_a ^ src_b;
    OP_SLT: value = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
    OP_SLL: value = src_b << sh;
    OP_ADDI: begin
      dst = inst[RT_MSB:RT_LSB];
      value = src_a + {16'h0000, imm};
    end
    OP_ORI: begin
      dst = inst[RT_MSB:RT_LSB];
      value = src_a | {16'h0000, imm};
    end
    // nop and every unlisted opcode
    default: writes = 1'b0;
  endcase

  if (writes && (dst != '0)) begin
    model_regs[dst] = value;
    return 1'b1;
  end
  return 1'b0;
endfunction

`endif

//--- bench/core_tb.sv
module core_tb import cpu_pkg::*; ();

  localparam int HOLD_LIMIT = 4;
  localparam int DRAIN_LIMIT = 20;

  logic      clk;
  logic      rst_n;
  logic      pair_valid;
  inst_t     inst0;
  inst_t     inst1;
  logic      hold;
  logic      retire_valid [NUM_LANES];
  reg_addr_t retire_dst [NUM_LANES];
  data_t     retire_data [NUM_LANES];

  string     test_name;
  logic      pair_held;
  reg_addr_t exp_dst_q [$];
  data_t     exp_data_q [$];
  string     exp_name_q [$];

  `include "core_model.svh"

  dual_issue_core dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pair_valid   (pair_valid),
    .inst0        (inst0),
    .inst1        (inst1),
    .hold         (hold),
    .retire_valid (retire_valid),
    .retire_dst   (retire_dst),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("Error: %s expected r%0d actual r%0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  function automatic inst_t rtype_word(input opcode_t op, input int rd, input int rs,
                                       input int rt, input int sh);
    inst_t w;
    w = '0;
    w[OPCODE_MSB:OPCODE_LSB] = op;
    w[RS_MSB:RS_LSB] = rs[4:0];
    w[RT_MSB:RT_LSB] = rt[4:0];
    w[RD_MSB:RD_LSB] = rd[4:0];
    w[SHAMT_MSB:SHAMT_LSB] = sh[4:0];
    return w;
  endfunction

  function automatic inst_t itype_word(input opcode_t op, input int rt, input int rs,
                                       input int imm);
    inst_t w;
    w = '0;
    w[OPCODE_MSB:OPCODE_LSB] = op;
    w[RS_MSB:RS_LSB] = rs[4:0];
    w[RT_MSB:RT_LSB] = rt[4:0];
    w[IMM_MSB:IMM_LSB] = imm[15:0];
    return w;
  endfunction

  // opcodes 10 and 11 are unlisted and act as nops
  function automatic inst_t random_inst();
    inst_t w;
    w = $urandom;
    w[OPCODE_MSB:OPCODE_LSB] = 6'($urandom % 12);
    w[RS_MSB:RS_LSB] = reg_addr_t'($urandom % 8);
    w[RT_MSB:RT_LSB] = reg_addr_t'($urandom % 8);
    w[RD_MSB:RD_LSB] = reg_addr_t'($urandom % 8);
    return w;
  endfunction

  task automatic expect_inst(input inst_t inst);
    reg_addr_t d;
    data_t     v;
    if (apply_inst(inst, d, v)) begin
      exp_dst_q.push_back(d);
      exp_data_q.push_back(v);
      exp_name_q.push_back(test_name);
    end
  endtask

  // pair is taken at the first edge that sees hold low
  task automatic send_pair(input inst_t i0, input inst_t i1);
    int waited;
    waited = 0;
    pair_held = 1'b0;
    @(posedge clk);
    pair_valid <= 1'b1;
    inst0 <= i0;
    inst1 <= i1;
    @(negedge clk);
    while (hold) begin
      pair_held = 1'b1;
      waited++;
      if (waited > HOLD_LIMIT) begin
        $display("hold stayed high for more than %0d cycles in %s", HOLD_LIMIT, test_name);
        abort_run();
      end
      @(negedge clk);
    end
    expect_inst(i0);
    expect_inst(i1);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      pair_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    pair_valid <= 1'b0;
    while (exp_dst_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("%0d expected writes never retired in %s", exp_dst_q.size(), test_name);
        abort_run();
      end
      @(negedge clk);
    end
    // room for any stray retire to show up
    repeat (4) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////

  task automatic compare_lane(input int lane);
    string name;
    if (exp_dst_q.size() == 0) begin
      $display("lane %0d retired r%0d with no write expected", lane, retire_dst[lane]);
      abort_run();
    end
    name = exp_name_q.pop_front();
    check_reg(name, exp_dst_q.pop_front(), retire_dst[lane]);
    check_data(name, exp_data_q.pop_front(), retire_data[lane]);
  endtask

  // lane 0 holds the older instruction
  always @(negedge clk) begin
    if (rst_n) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (retire_valid[l]) begin
          compare_lane(l);
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h2e65));
    rst_n = 1'b0;
    pair_valid = 1'b0;
    inst0 = '0;
    inst1 = '0;
    pair_held = 1'b0;
    test_name = "reset";
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "rtype_basic";
    send_pair(itype_word(OP_ADDI, 1, 0, 'h1234), itype_word(OP_ORI, 2, 0, 'hf0f0));
    send_pair(itype_word(OP_ADDI, 3, 0, 'h0007), rtype_word(OP_SUB, 4, 0, 1, 0));
    check_flag("rtype_basic hold", 1'b0, pair_held);
    send_pair(rtype_word(OP_ADD, 5, 1, 2, 0), rtype_word(OP_SUB, 6, 2, 1, 0));
    send_pair(rtype_word(OP_AND, 7, 1, 2, 0), rtype_word(OP_OR, 8, 1, 2, 0));
    send_pair(rtype_word(OP_XOR, 9, 1, 2, 0), rtype_word(OP_SLT, 10, 4, 1, 0));
    send_pair(rtype_word(OP_SLT, 11, 1, 4, 0), rtype_word(OP_SLT, 12, 3, 1, 0));
    drain();

    test_name = "imm_shift_r0";
    send_pair(itype_word(OP_ADDI, 13, 2, 'hffff), itype_word(OP_ORI, 14, 1, 'h8000));
    send_pair(rtype_word(OP_SLL, 15, 0, 3, 5), rtype_word(OP_SLL, 16, 0, 1, 31));
    send_pair(itype_word(OP_ADDI, 0, 1, 'h55), rtype_word(OP_ADD, 0, 1, 2, 0));
    send_pair(rtype_word(OP_OR, 17, 0, 1, 0), rtype_word(OP_ADD, 18, 0, 0, 0));
    send_pair({6'd63, 26'h3ffffff}, rtype_word(OP_NOP, 19, 1, 2, 0));
    send_pair(rtype_word(OP_ADD, 20, 19, 0, 0), rtype_word(OP_NOP, 0, 0, 0, 0));
    drain();

    test_name = "fwd_bypass";
    send_pair(itype_word(OP_ADDI, 20, 0, 'h11), itype_word(OP_ADDI, 21, 0, 'h22));
    send_pair(rtype_word(OP_ADD, 22, 20, 21, 0), rtype_word(OP_SUB, 23, 21, 20, 0));
    send_pair(rtype_word(OP_ADD, 24, 22, 20, 0), rtype_word(OP_XOR, 25, 23, 21, 0));
    send_pair(rtype_word(OP_ADD, 26, 24, 22, 0), rtype_word(OP_OR, 27, 25, 20, 0));
    idle(1);
    send_pair(rtype_word(OP_ADD, 28, 26, 27, 0), rtype_word(OP_SUB, 29, 22, 25, 0));
    drain();

    test_name = "hold_split";
    send_pair(itype_word(OP_ADDI, 1, 0, 'h40), rtype_word(OP_ADD, 2, 1, 1, 0));
    check_flag("hold_split first pair", 1'b1, pair_held);
    send_pair(itype_word(OP_ORI, 3, 2, 'h1), rtype_word(OP_SLL, 4, 0, 3, 2));
    check_flag("hold_split second pair", 1'b1, pair_held);
    send_pair(rtype_word(OP_ADD, 5, 4, 2, 0), rtype_word(OP_NOP, 0, 0, 0, 0));
    send_pair(rtype_word(OP_ADD, 6, 1, 2, 0), rtype_word(OP_SUB, 7, 3, 4, 0));
    check_flag("hold_split independent pair", 1'b0, pair_held);
    drain();

    test_name = "same_dst";
    send_pair(rtype_word(OP_ADD, 9, 1, 2, 0), rtype_word(OP_SUB, 9, 2, 1, 0));
    check_flag("same_dst hold", 1'b0, pair_held);
    send_pair(rtype_word(OP_OR, 10, 9, 0, 0), rtype_word(OP_OR, 12, 1, 0, 0));
    send_pair(rtype_word(OP_ADD, 11, 9, 0, 0), rtype_word(OP_XOR, 13, 9, 1, 0));
    idle(3);
    send_pair(rtype_word(OP_OR, 14, 9, 0, 0), rtype_word(OP_NOP, 0, 0, 0, 0));
    drain();

    test_name = "random_pairs";
    for (int n = 0; n < 400; n++) begin
      send_pair(random_inst(), random_inst());
      if (($urandom % 8) == 0) begin
        idle(1);
      end
    end
    drain();

    if (exp_dst_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("%0d expected writes left over at the end", exp_dst_q.size());
      abort_run();
    end
  end

endmodule

//--- sim.f
+incdir+bench
design/cpu_pkg.sv
design/issue_steer.sv
design/alu_lane.sv
design/register_file.sv
design/dual_issue_core.sv
bench/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dual-issue core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module core_tb \
  -o core_tb_sim

# the log decides pass or fail, a stopped run simply lacks the line
./obj_dir/core_tb_sim 2>&1 | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
